// File: Makefile
VERILATOR ?= verilator
TOP       := tb_op_imm_ctrl
FLIST     := op_imm_ctrl.f
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := STATUS: FAIL

SOURCES   := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/op_imm_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module op_imm_ctrl (
  input  wire                            clk_i,
  input  wire                            rst_i,
  input  wire [op_imm_pkg::IR_W-1:0]     ir_i,     // Held for the whole insn
  input  wire                            trap_i,
  input  wire                            ack_i,
  output logic                           defined_o,
  output logic                           alua_rf_o,
  output logic                           alub_imm6i_o,
  output logic                           alub_imm12_o,
  output logic                           ra_ir1_o,
  output logic                           ra_ird_o,
  output logic                           rf_alu_o,
  output logic [op_imm_pkg::RMASK_W-1:0] rmask_o,
  output logic                           cflag_1_o,
  output logic                           sum_en_o,
  output logic                           and_en_o,
  output logic                           xor_en_o,
  output logic                           invb_en_o,
  output logic                           lsh_en_o,
  output logic                           rsh_en_o,
  output logic                           ltu_en_o,
  output logic                           lts_en_o,
  output logic                           sx32_en_o,
  output logic                           adr_npc_o,
  output logic                           adr_mtvec_o,
  output logic                           npc_mtvec_o,
  output logic                           mepc_npc_o,
  output logic                           mepc_cpc_o,
  output logic                           mpie_mie_o,
  output logic                           mie_0_o,
  output logic                           mcause_we_o,
  output logic                           adr_npc_plus2_o,
  output logic                           size_2_o,
  output logic                           vpa_o,
  output logic                           we_o,
  output logic                           irl_dat_o,
  output logic                           irh_dat_o,
  output logic                           ir_dat_irl_o,
  output logic                           cpc_npc_o,
  output logic                           npc_npc_plus4_o
);

  op_imm_pkg::phase_t phase;

  // Phase counter, fetch and trap strobes
  op_imm_seq u_op_imm_seq (
    .phase_o   (phase),
    .defined_i (defined_o),  // Only decode to sequencing path
    .*
  );

  op_imm_decode u_op_imm_decode (
    .phase_i (phase),
    .*
  );

endmodule

`default_nettype wire

// File: design/op_imm_decode.sv
`timescale 1ns/1ps
`default_nettype none

module op_imm_decode (
  input  wire [op_imm_pkg::IR_W-1:0] ir_i,
  input  wire op_imm_pkg::phase_t    phase_i,
  output logic                       defined_o,
  output logic                       alua_rf_o,
  output logic                       alub_imm6i_o,
  output logic                       alub_imm12_o,
  output logic                       ra_ir1_o,
  output logic                       ra_ird_o,
  output logic                       rf_alu_o,
  output logic [op_imm_pkg::RMASK_W-1:0] rmask_o,
  output logic                       cflag_1_o,
  output logic                       sum_en_o,
  output logic                       and_en_o,
  output logic                       xor_en_o,
  output logic                       invb_en_o,
  output logic                       lsh_en_o,
  output logic                       rsh_en_o,
  output logic                       ltu_en_o,
  output logic                       lts_en_o,
  output logic                       sx32_en_o
);

  logic [2:0] funct3;
  logic [5:0] funct7_hi;
  logic       w_form;
  logic       opc_ok;
  logic       funct_ok;
  logic       is_shift;
  logic       defined;
  logic       exec_en;
  // ALU function from funct3/funct7 before phase gating
  logic       op_sum;
  logic       op_and;
  logic       op_xor;
  logic       op_invb;
  logic       op_lsh;
  logic       op_rsh;
  logic       op_ltu;
  logic       op_lts;
  logic       op_cflag;

  assign funct3    = ir_i[op_imm_pkg::F3_LSB +: 3];
  assign funct7_hi = ir_i[op_imm_pkg::F7_LSB +: 6];
  assign w_form    = ir_i[op_imm_pkg::IR_W_BIT];

  assign opc_ok = (ir_i[1:0] == op_imm_pkg::OPC_QUAD) &&
                  (ir_i[6:5] == op_imm_pkg::OPC_OP_IMM_HI) &&
                  ((ir_i[4:2] == op_imm_pkg::OPC_OP_IMM_MAJ[0]) ||
                   (ir_i[4:2] == op_imm_pkg::OPC_OP_IMM_MAJ[1]));

  always_comb begin
    op_sum   = 1'b0;
    op_and   = 1'b0;
    op_xor   = 1'b0;
    op_invb  = 1'b0;
    op_lsh   = 1'b0;
    op_rsh   = 1'b0;
    op_ltu   = 1'b0;
    op_lts   = 1'b0;
    op_cflag = 1'b0;
    is_shift = 1'b0;
    funct_ok = 1'b1;
    case (funct3)
      op_imm_pkg::F3_ADDI: op_sum = 1'b1;
      op_imm_pkg::F3_SLTI: begin
        op_lts   = 1'b1;
        op_invb  = 1'b1;  // a - b via a + ~b + 1
        op_cflag = 1'b1;
      end
      op_imm_pkg::F3_SLTIU: begin
        op_ltu   = 1'b1;
        op_invb  = 1'b1;
        op_cflag = 1'b1;
      end
      op_imm_pkg::F3_XORI: op_xor = 1'b1;
      op_imm_pkg::F3_ORI: begin
        op_and = 1'b1;  // OR built as AND plus XOR
        op_xor = 1'b1;
      end
      op_imm_pkg::F3_ANDI: op_and = 1'b1;
      op_imm_pkg::F3_SLLI: begin
        is_shift = 1'b1;
        op_lsh   = 1'b1;
        funct_ok = (funct7_hi == op_imm_pkg::F7_SHL);
      end
      op_imm_pkg::F3_SRLI: begin  // SRLI, SRAI
        is_shift = 1'b1;
        op_rsh   = 1'b1;
        op_cflag = (funct7_hi == op_imm_pkg::F7_SRA);  // Sign fill
        funct_ok = (funct7_hi == op_imm_pkg::F7_SHL) ||
                   (funct7_hi == op_imm_pkg::F7_SRA);
      end
    endcase
    // W shifts only take a 5-bit shamt
    if (is_shift && w_form && ir_i[op_imm_pkg::F7_LSB-1]) begin
      funct_ok = 1'b0;
    end
  end

  assign defined   = opc_ok & funct_ok;
  assign defined_o = defined;
  assign exec_en   = defined & (phase_i == op_imm_pkg::PH_EXEC);

  assign alub_imm6i_o = defined & is_shift & (phase_i == op_imm_pkg::PH_ISSUE);
  assign alub_imm12_o = defined & ~is_shift & (phase_i == op_imm_pkg::PH_ISSUE);
  assign ra_ir1_o     = defined & (phase_i == op_imm_pkg::PH_READ);  // rs1 address
  assign alua_rf_o    = exec_en;
  assign ra_ird_o     = exec_en;
  assign rf_alu_o     = exec_en;
  assign rmask_o      = {op_imm_pkg::RMASK_W{exec_en}};

  assign sum_en_o  = exec_en & op_sum;
  assign and_en_o  = exec_en & op_and;
  assign xor_en_o  = exec_en & op_xor;
  assign invb_en_o = exec_en & op_invb;
  assign lsh_en_o  = exec_en & op_lsh;
  assign rsh_en_o  = exec_en & op_rsh;
  assign ltu_en_o  = exec_en & op_ltu;
  assign lts_en_o  = exec_en & op_lts;
  assign cflag_1_o = exec_en & op_cflag;
  assign sx32_en_o = exec_en & w_form;

endmodule

`default_nettype wire

// File: design/op_imm_pkg.sv
`default_nettype none

package op_imm_pkg;

  // Instruction cycle phases
  typedef enum logic [1:0] {
    PH_ISSUE    = 2'd0,
    PH_READ     = 2'd1,
    PH_EXEC     = 2'd2,
    PH_FETCH_HI = 2'd3
  } phase_t;

  localparam int IR_W    = 32;
  localparam int RMASK_W = 4;  // Byte lanes of the RF write

  // Field positions within the instruction word
  localparam int F3_LSB   = 12;
  localparam int F7_LSB   = 26;  // Upper six funct7 bits only
  localparam int IR_W_BIT = 3;   // Set for OP-IMM-32

  localparam logic [1:0] OPC_QUAD = 2'b11;
  localparam logic [1:0] OPC_OP_IMM_HI = 2'b00;  // Opcode bits 6:5
  localparam logic [2:0] OPC_OP_IMM_MAJ [2] = '{3'd4, 3'd6};  // OP-IMM, OP-IMM-32

  localparam logic [2:0] F3_ADDI  = 3'b000;
  localparam logic [2:0] F3_SLLI  = 3'b001;
  localparam logic [2:0] F3_SLTI  = 3'b010;
  localparam logic [2:0] F3_SLTIU = 3'b011;
  localparam logic [2:0] F3_XORI  = 3'b100;
  localparam logic [2:0] F3_SRLI  = 3'b101;  // SRAI shares it
  localparam logic [2:0] F3_ORI   = 3'b110;
  localparam logic [2:0] F3_ANDI  = 3'b111;

  // Bit 25 is shamt[5] on RV64
  localparam logic [5:0] F7_SHL = 6'b000000;
  localparam logic [5:0] F7_SRA = 6'b010000;

endpackage

`default_nettype wire

// File: design/op_imm_seq.sv
`timescale 1ns/1ps
`default_nettype none

module op_imm_seq (
  input  wire  clk_i,
  input  wire  rst_i,
  input  wire  defined_i,
  input  wire  trap_i,
  input  wire  ack_i,
  output op_imm_pkg::phase_t phase_o,
  output logic adr_npc_o,
  output logic adr_mtvec_o,
  output logic npc_mtvec_o,
  output logic mepc_npc_o,
  output logic mepc_cpc_o,
  output logic mpie_mie_o,
  output logic mie_0_o,
  output logic mcause_we_o,
  output logic adr_npc_plus2_o,
  output logic size_2_o,
  output logic vpa_o,
  output logic we_o,
  output logic irl_dat_o,
  output logic irh_dat_o,
  output logic ir_dat_irl_o,
  output logic cpc_npc_o,
  output logic npc_npc_plus4_o
);

  op_imm_pkg::phase_t phase_q;
  op_imm_pkg::phase_t phase_d;
  logic s_issue;
  logic s_read;
  logic s_exec;
  logic s_fetch_hi;
  logic take_trap;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      phase_q <= op_imm_pkg::PH_ISSUE;
    end else begin
      phase_q <= phase_d;
    end
  end

  always_comb begin
    case (phase_q)
      op_imm_pkg::PH_ISSUE:    phase_d = op_imm_pkg::PH_READ;
      op_imm_pkg::PH_READ:     phase_d = op_imm_pkg::PH_EXEC;
      op_imm_pkg::PH_EXEC:     phase_d = op_imm_pkg::PH_FETCH_HI;
      // Undefined opcode parks here until reset
      default: phase_d = defined_i ? op_imm_pkg::PH_ISSUE : op_imm_pkg::PH_FETCH_HI;
    endcase
  end

  assign phase_o = phase_q;

  assign s_issue    = (phase_q == op_imm_pkg::PH_ISSUE);
  assign s_read     = (phase_q == op_imm_pkg::PH_READ);
  assign s_exec     = (phase_q == op_imm_pkg::PH_EXEC);
  assign s_fetch_hi = (phase_q == op_imm_pkg::PH_FETCH_HI);

  assign take_trap = ~defined_i | trap_i;  // Illegal insn or pending trap

  // Trap entry strobes in ISSUE
  assign adr_mtvec_o = s_issue & take_trap;
  assign npc_mtvec_o = s_issue & take_trap;
  assign mpie_mie_o  = s_issue & take_trap;
  assign mie_0_o     = s_issue & take_trap;
  assign mcause_we_o = s_issue & take_trap;
  assign mepc_cpc_o  = s_issue & ~defined_i;           // Faulting insn
  assign mepc_npc_o  = s_issue & defined_i & trap_i;   // Resume after insn

  // Fetch of the next instruction
  assign adr_npc_o       = (s_issue & ~take_trap) | s_read;
  assign adr_npc_plus2_o = s_exec | s_fetch_hi;
  assign size_2_o        = 1'b1;
  assign vpa_o           = 1'b1;
  assign we_o            = 1'b0;
  assign irl_dat_o       = s_read & ack_i;
  assign irh_dat_o       = s_fetch_hi & ack_i;
  assign ir_dat_irl_o    = s_fetch_hi & ack_i;
  assign cpc_npc_o       = s_fetch_hi & ack_i;
  assign npc_npc_plus4_o = s_fetch_hi & ack_i;

endmodule

`default_nettype wire

// File: op_imm_ctrl.f
design/op_imm_pkg.sv
design/op_imm_seq.sv
design/op_imm_decode.sv
design/op_imm_ctrl.sv
tests/op_imm_ctrl_sva.sv
tests/tb_op_imm_ctrl.sv

// File: tests/op_imm_ctrl_sva.sv
`timescale 1ns/1ps
`default_nettype none

module op_imm_ctrl_sva (
  input wire                            clk_i,
  input wire                            rst_i,
  input wire op_imm_pkg::phase_t        phase_i,
  input wire                            adr_npc_i,
  input wire                            adr_mtvec_i,
  input wire                            rf_alu_i,
  input wire [op_imm_pkg::RMASK_W-1:0]  rmask_i
);

  logic wb_any;

  assign wb_any = rf_alu_i | (|rmask_i);  // Any RF writeback strobe

  a_fetch_or_trap: assert property (@(posedge clk_i) disable iff (rst_i)
    !(adr_npc_i && adr_mtvec_i))
    else $error("adr_npc_o and adr_mtvec_o high together");

  a_issue_to_read: assert property (@(posedge clk_i) disable iff (rst_i)
    (phase_i == op_imm_pkg::PH_ISSUE) |=> (phase_i == op_imm_pkg::PH_READ))
    else $error("phase did not move from ISSUE to READ");

  a_wb_in_exec: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_any |-> (phase_i == op_imm_pkg::PH_EXEC))
    else $error("writeback enable outside EXEC");

endmodule

bind op_imm_ctrl op_imm_ctrl_sva u_op_imm_ctrl_sva (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .phase_i     (phase),
  .adr_npc_i   (adr_npc_o),
  .adr_mtvec_i (adr_mtvec_o),
  .rf_alu_i    (rf_alu_o),
  .rmask_i     (rmask_o)
);

`default_nettype wire

// File: tests/op_imm_trace.txt
// Per cycle: test, ir_i, {rst_i,trap_i,ack_i}, decode outputs, fetch/trap outputs; 2 per line
// Output columns are packed MSB first as dec_act and seq_act in tb_op_imm_ctrl
01 00510093 1 A00000 80600  01 00510093 1 900000 80680
01 00510093 1 8EF400 00E00  01 00510093 1 800000 00E78
02 00512093 1 A00000 80600  02 00512093 1 900000 80680
02 00512093 1 8EF888 00E00  02 00512093 1 800000 00E78
03 00513093 1 A00000 80600  03 00513093 1 900000 80680
03 00513093 1 8EF890 00E00  03 00513093 1 800000 00E78
04 00514093 1 A00000 80600  04 00514093 1 900000 80680
04 00514093 1 8EF100 00E00  04 00514093 1 800000 00E78
05 00516093 1 A00000 80600  05 00516093 1 900000 80680
05 00516093 1 8EF300 00E00  05 00516093 1 800000 00E78
06 00517093 1 A00000 80600  06 00517093 1 900000 80680
06 00517093 1 8EF200 00E00  06 00517093 1 800000 00E78
07 02111093 1 C00000 80600  07 02111093 1 900000 80680
07 02111093 1 8EF040 00E00  07 02111093 1 800000 00E78
08 00515093 1 C00000 80600  08 00515093 1 900000 80680
08 00515093 1 8EF020 00E00  08 00515093 1 800000 00E78
09 40515093 1 C00000 80600  09 40515093 1 900000 80680
09 40515093 1 8EF820 00E00  09 40515093 1 800000 00E78
0A 4051509B 1 C00000 80600  0A 4051509B 1 900000 80680
0A 4051509B 1 8FF820 00E00  0A 4051509B 1 800000 00E78
0B 00510093 3 A00000 77600  0B 00510093 3 900000 80680
0B 00510093 3 8EF400 00E00  0B 00510093 3 800000 00E78
0C 00514093 0 A00000 80600  0C 00514093 0 900000 80600
0C 00514093 0 8EF100 00E00  0C 00514093 0 800000 00E00
0D 0211109B 1 000000 6F600  0D 0211109B 1 000000 80680
0D 0211109B 1 000000 00E00  0D 0211109B 1 000000 00E78
0D 0211109B 1 000000 00E78  0D 0211109B 5 000000 00E78
0E 003100B3 1 000000 6F600  0E 003100B3 1 000000 80680
0E 003100B3 1 000000 00E00  0E 003100B3 1 000000 00E78
0E 003100B3 1 000000 00E78  0E 003100B3 1 000000 00E78

// File: tests/tb_op_imm_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_op_imm_ctrl;

  localparam int REC_W   = 5;    // Words per cycle record
  localparam int MAX_REC = 100;
  localparam int RST_CYC = 8;

  logic                        clk_i;
  logic                        rst_i;
  logic [op_imm_pkg::IR_W-1:0] ir_i;
  logic                        trap_i;
  logic                        ack_i;

  wire defined_o, alua_rf_o, alub_imm6i_o, alub_imm12_o, ra_ir1_o, ra_ird_o, rf_alu_o;
  wire [op_imm_pkg::RMASK_W-1:0] rmask_o;
  wire cflag_1_o, sum_en_o, and_en_o, xor_en_o, invb_en_o;
  wire lsh_en_o, rsh_en_o, ltu_en_o, lts_en_o, sx32_en_o;
  wire adr_npc_o, adr_mtvec_o, npc_mtvec_o, mepc_npc_o, mepc_cpc_o;
  wire mpie_mie_o, mie_0_o, mcause_we_o, adr_npc_plus2_o;
  wire size_2_o, vpa_o, we_o, irl_dat_o, irh_dat_o;
  wire ir_dat_irl_o, cpc_npc_o, npc_npc_plus4_o;

  // Same bit order as the trace columns
  wire [23:0] dec_act = {defined_o, alub_imm6i_o, alub_imm12_o, ra_ir1_o,
                         alua_rf_o, ra_ird_o, rf_alu_o, sx32_en_o, rmask_o,
                         cflag_1_o, sum_en_o, and_en_o, xor_en_o,
                         invb_en_o, lsh_en_o, rsh_en_o, ltu_en_o, lts_en_o, 3'b000};
  wire [19:0] seq_act = {adr_npc_o, adr_mtvec_o, npc_mtvec_o, mepc_npc_o,
                         mepc_cpc_o, mpie_mie_o, mie_0_o, mcause_we_o,
                         adr_npc_plus2_o, size_2_o, vpa_o, we_o,
                         irl_dat_o, irh_dat_o, ir_dat_irl_o, cpc_npc_o,
                         npc_npc_plus4_o, 3'b000};

  string dec_names [24] = '{"defined_o", "alub_imm6i_o", "alub_imm12_o", "ra_ir1_o",
    "alua_rf_o", "ra_ird_o", "rf_alu_o", "sx32_en_o",
    "rmask_o[3]", "rmask_o[2]", "rmask_o[1]", "rmask_o[0]",
    "cflag_1_o", "sum_en_o", "and_en_o", "xor_en_o",
    "invb_en_o", "lsh_en_o", "rsh_en_o", "ltu_en_o", "lts_en_o", "", "", ""};
  string seq_names [20] = '{"adr_npc_o", "adr_mtvec_o", "npc_mtvec_o", "mepc_npc_o",
    "mepc_cpc_o", "mpie_mie_o", "mie_0_o", "mcause_we_o",
    "adr_npc_plus2_o", "size_2_o", "vpa_o", "we_o",
    "irl_dat_o", "irh_dat_o", "ir_dat_irl_o", "cpc_npc_o",
    "npc_npc_plus4_o", "", "", ""};

  logic [31:0] trace [MAX_REC*REC_W];
  int n_rec;
  int cur_test;
  int test_errs;
  int total_errs;
  int n_tests;
  int failed_tests;
  int cyc_cnt = 0;
  int cyc_limit = MAX_REC + RST_CYC + 20;

  op_imm_ctrl u_op_imm_ctrl (.*);

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cyc_cnt++;
    if (cyc_cnt > cyc_limit) begin
      $display("timeout: run did not finish within %0d cycles", cyc_limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic check_outputs(input logic [23:0] dec_exp, input logic [19:0] seq_exp);
    int b;
    for (b = 0; b < 24; b++) begin
      if (dec_names[b] != "") begin
        assert (dec_act[23-b] === dec_exp[23-b]) else begin
          $display("ERR %s exp=%h act=%h (test %0d, cycle %0d)", dec_names[b],
                   dec_exp[23-b], dec_act[23-b], cur_test, cyc_cnt);
          test_errs++;
        end
      end
    end
    for (b = 0; b < 20; b++) begin
      if (seq_names[b] != "") begin
        assert (seq_act[19-b] === seq_exp[19-b]) else begin
          $display("ERR %s exp=%h act=%h (test %0d, cycle %0d)", seq_names[b],
                   seq_exp[19-b], seq_act[19-b], cur_test, cyc_cnt);
          test_errs++;
        end
      end
    end
  endtask

  initial begin
    int r;
    rst_i  = 1'b1;
    ir_i   = '0;
    trap_i = 1'b0;
    ack_i  = 1'b0;
    total_errs   = 0;
    test_errs    = 0;
    n_tests      = 0;
    failed_tests = 0;
    $readmemh("tests/op_imm_trace.txt", trace);
    n_rec = 0;
    while (n_rec < MAX_REC && trace[n_rec*REC_W] != '0) begin  // Test 0 or X ends it
      n_rec++;
    end
    cyc_limit = n_rec + RST_CYC + 20;
    if (n_rec == 0) begin
      $display("trace file held no records");
      total_errs++;
    end
    repeat (RST_CYC) @(posedge clk_i);
    for (r = 0; r < n_rec; r++) begin
      @(negedge clk_i);
      cur_test = trace[r*REC_W];
      ir_i     = trace[r*REC_W+1];
      {rst_i, trap_i, ack_i} = trace[r*REC_W+2][2:0];
      #1;  // Half way to the rising edge
      check_outputs(trace[r*REC_W+3][23:0], trace[r*REC_W+4][19:0]);
      if (r == n_rec - 1 || trace[(r+1)*REC_W] != cur_test) begin
        $display("test %0d: %s, %0d mismatches", cur_test,
                 (test_errs == 0) ? "ok" : "failed", test_errs);
        n_tests++;
        if (test_errs != 0) failed_tests++;
        total_errs += test_errs;
        test_errs = 0;
      end
    end
    $display("tests %0d, failed %0d, mismatches %0d", n_tests, failed_tests, total_errs);
    if (total_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
